// File: source/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  // load kinds, RISC-V funct3 encoding
  typedef enum logic [2:0] {
    LD_BS = 3'b000,
    LD_HS = 3'b001,
    LD_W  = 3'b010,
    LD_BU = 3'b100,
    LD_HU = 3'b101
  } load_func_t;

  // store kinds, unknown codes behave as a byte store
  typedef enum logic [2:0] {
    ST_B = 3'b000,
    ST_H = 3'b001,
    ST_W = 3'b010
  } store_func_t;

endpackage

`default_nettype wire

// File: source/axi_pkg.sv
`default_nettype none

package axi_pkg;

  localparam int AXI_ADDR_W  = 32;
  localparam int AXI_RDATA_W = 32;
  localparam int AXI_WDATA_W = 64;
  localparam int AXI_STRB_W  = AXI_WDATA_W / 8;

  // one doubleword, seen as byte lanes or as two 32-bit words
  typedef union packed {
    logic [AXI_STRB_W-1:0][7:0] bytes;
    logic [AXI_WDATA_W/AXI_RDATA_W-1:0][AXI_RDATA_W-1:0] words;
  } mem_word_u;

endpackage

`default_nettype wire

// File: source/axi_lite_r_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axi_lite_r_if;
  import axi_pkg::*;

  // read address channel
  logic                   arvalid;
  logic                   arready;
  logic [AXI_ADDR_W-1:0]  araddr;

  // read data channel
  logic                   rvalid;
  logic                   rready;
  logic [AXI_RDATA_W-1:0] rdata;

  modport master (
    output arvalid, araddr, rready,
    input  arready, rvalid, rdata
  );

  modport slave (
    input  arvalid, araddr, rready,
    output arready, rvalid, rdata
  );

endinterface

`default_nettype wire

// File: source/axi_w_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axi_w_if;
  import axi_pkg::*;

  // write address channel
  logic                  awvalid;
  logic                  awready;
  logic [AXI_ADDR_W-1:0] awaddr;

  // write data channel, strobe gives the size
  logic                  wvalid;
  logic                  wready;
  mem_word_u             wdata;
  logic [AXI_STRB_W-1:0] wstrb;

  // write response, no error codes
  logic                  bvalid;
  logic                  bready;

  modport master (
    output awvalid, awaddr,
    output wvalid, wdata, wstrb,
    output bready,
    input  awready, wready, bvalid
  );

  modport slave (
    input  awvalid, awaddr,
    input  wvalid, wdata, wstrb,
    input  bready,
    output awready, wready, bvalid
  );

endinterface

`default_nettype wire

// File: source/lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu (
  input  logic                           clk,
  input  logic                           rstn,

  // load request and response
  input  logic [axi_pkg::AXI_ADDR_W-1:0] raddr,
  input  lsu_pkg::load_func_t            rfunc,
  input  logic                           rreq_valid,
  output logic                           rreq_ready,
  output logic [31:0]                    rdata,
  output logic                           rres_valid,
  input  logic                           rres_ready,

  // store request and response
  input  logic [axi_pkg::AXI_ADDR_W-1:0] waddr,
  input  logic [31:0]                    wdata,
  input  lsu_pkg::store_func_t           wfunc,
  input  logic                           wreq_valid,
  output logic                           wreq_ready,
  output logic                           wres_valid,
  input  logic                           wres_ready,

  // memory side
  axi_lite_r_if.master                   ram_r,
  axi_w_if.master                        ram_w
);
  import lsu_pkg::*;
  import axi_pkg::*;

  // load path
  logic [1:0]             roff_q;
  load_func_t             rfunc_q;
  logic [AXI_RDATA_W-1:0] rdata_shifted;

  // one load in flight, keep what the response needs
  always_ff @(posedge clk) begin
    if (rreq_valid && rreq_ready) begin
      roff_q  <= raddr[1:0];
      rfunc_q <= rfunc;
    end
  end

  assign ram_r.arvalid = rreq_valid;
  assign ram_r.araddr  = raddr;
  assign rreq_ready    = ram_r.arready;

  // move the addressed byte down to bit 0
  assign rdata_shifted = ram_r.rdata >> {roff_q, 3'b000};

  always_comb begin
    case (rfunc_q)
      LD_BS:   rdata = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
      LD_BU:   rdata = {24'h0, rdata_shifted[7:0]};
      LD_HS:   rdata = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
      LD_HU:   rdata = {16'h0, rdata_shifted[15:0]};
      // word, also anything unknown
      default: rdata = rdata_shifted;
    endcase
  end

  assign rres_valid  = ram_r.rvalid;
  assign ram_r.rready = rres_ready;

  // store path
  mem_word_u             wdata_aligned;
  logic [AXI_STRB_W-1:0] wmask_base;
  logic [AXI_STRB_W-1:0] wmask_aligned;
  logic                  aw_done;
  logic                  w_done;

  // data into the byte lanes of the doubleword
  assign wdata_aligned = {{(AXI_WDATA_W-32){1'b0}}, wdata} << {waddr[2:0], 3'b000};

  always_comb begin
    case (wfunc)
      ST_H:    wmask_base = 8'b0000_0011;
      ST_W:    wmask_base = 8'b0000_1111;
      default: wmask_base = 8'b0000_0001;
    endcase
  end

  assign wmask_aligned = wmask_base << waddr[2:0];

  // which channels of the current store were already taken
  always_ff @(posedge clk) begin
    if (!rstn) begin
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else if (ram_w.bvalid && ram_w.bready) begin
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      if (ram_w.awvalid && ram_w.awready) begin
        aw_done <= 1'b1;
      end
      if (ram_w.wvalid && ram_w.wready) begin
        w_done <= 1'b1;
      end
    end
  end

  assign ram_w.awaddr  = {waddr[AXI_ADDR_W-1:3], 3'b000};
  assign ram_w.awvalid = wreq_valid && !aw_done;
  assign ram_w.wdata   = wdata_aligned;
  assign ram_w.wstrb   = wmask_aligned;
  assign ram_w.wvalid  = wreq_valid && !w_done;

  // both flags set means the store is waiting for its response
  assign wreq_ready = !(aw_done && w_done) &&
                      (ram_w.awready || aw_done) &&
                      (ram_w.wready || w_done);

  assign wres_valid   = ram_w.bvalid;
  assign ram_w.bready = wres_ready;

endmodule

`default_nettype wire

// File: source/axi_sram.sv
`timescale 1ns/1ps
`default_nettype none

module axi_sram #(
  parameter int MEM_DEPTH = 256
) (
  input  logic         clk,
  input  logic         rstn,
  axi_lite_r_if.slave  s_r,
  axi_w_if.slave       s_w
);
  import axi_pkg::*;

  localparam int IDX_W = $clog2(MEM_DEPTH);

  mem_word_u mem [MEM_DEPTH];

  // read side
  logic                   rvalid_q;
  logic [AXI_RDATA_W-1:0] rdata_q;
  logic                   ar_fire;
  mem_word_u              rd_word;

  // free when idle or when the pending beat leaves this cycle
  assign s_r.arready = !rvalid_q || s_r.rready;
  assign ar_fire     = s_r.arvalid && s_r.arready;
  assign rd_word     = mem[s_r.araddr[IDX_W+2:3]];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rvalid_q <= 1'b0;
    end else if (ar_fire) begin
      rvalid_q <= 1'b1;
    end else if (s_r.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  // bit 2 picks the word lane
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      rdata_q <= rd_word.words[s_r.araddr[2]];
    end
  end

  assign s_r.rvalid = rvalid_q;
  assign s_r.rdata  = rdata_q;

  // write side
  logic                  aw_held;
  logic                  w_held;
  logic                  bvalid_q;
  logic [IDX_W-1:0]      aw_idx_q;
  mem_word_u             wdata_q;
  logic [AXI_STRB_W-1:0] wstrb_q;
  logic                  aw_fire;
  logic                  w_fire;
  logic                  wr_en;
  logic [IDX_W-1:0]      wr_idx;
  mem_word_u             wr_word;
  logic [AXI_STRB_W-1:0] wr_strb;

  assign s_w.awready = !bvalid_q && !aw_held;
  assign s_w.wready  = !bvalid_q && !w_held;
  assign aw_fire     = s_w.awvalid && s_w.awready;
  assign w_fire      = s_w.wvalid && s_w.wready;

  // a held beat or the one arriving now
  assign wr_idx  = aw_held ? aw_idx_q : s_w.awaddr[IDX_W+2:3];
  assign wr_word = w_held ? wdata_q : s_w.wdata;
  assign wr_strb = w_held ? wstrb_q : s_w.wstrb;
  assign wr_en   = (aw_held || aw_fire) && (w_held || w_fire);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      aw_held  <= 1'b0;
      w_held   <= 1'b0;
      bvalid_q <= 1'b0;
    end else if (wr_en) begin
      aw_held  <= 1'b0;
      w_held   <= 1'b0;
      bvalid_q <= 1'b1;
    end else begin
      if (aw_fire) begin
        aw_held <= 1'b1;
      end
      if (w_fire) begin
        w_held <= 1'b1;
      end
      if (bvalid_q && s_w.bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      aw_idx_q <= s_w.awaddr[IDX_W+2:3];
    end
    if (w_fire) begin
      wdata_q <= s_w.wdata;
      wstrb_q <= s_w.wstrb;
    end
  end

  // strobed byte write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < AXI_STRB_W; b++) begin
        if (wr_strb[b]) begin
          mem[wr_idx].bytes[b] <= wr_word.bytes[b];
        end
      end
    end
  end

  assign s_w.bvalid = bvalid_q;

endmodule

`default_nettype wire

// File: source/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
  parameter int MEM_DEPTH = 256
) (
  input  logic                  clk,
  input  logic                  rstn,

  // loads
  input  logic                  rd_req_valid,
  output logic                  rd_req_ready,
  input  logic [31:0]           rd_addr,
  input  lsu_pkg::load_func_t   rd_func,
  output logic                  rd_resp_valid,
  input  logic                  rd_resp_ready,
  output logic [31:0]           rd_data,

  // stores
  input  logic                  wr_req_valid,
  output logic                  wr_req_ready,
  input  logic [31:0]           wr_addr,
  input  logic [31:0]           wr_data,
  input  lsu_pkg::store_func_t  wr_func,
  output logic                  wr_resp_valid,
  input  logic                  wr_resp_ready
);

  axi_lite_r_if ram_r ();
  axi_w_if      ram_w ();

  lsu i_lsu (
    .clk        (clk),
    .rstn       (rstn),
    .raddr      (rd_addr),
    .rfunc      (rd_func),
    .rreq_valid (rd_req_valid),
    .rreq_ready (rd_req_ready),
    .rdata      (rd_data),
    .rres_valid (rd_resp_valid),
    .rres_ready (rd_resp_ready),
    .waddr      (wr_addr),
    .wdata      (wr_data),
    .wfunc      (wr_func),
    .wreq_valid (wr_req_valid),
    .wreq_ready (wr_req_ready),
    .wres_valid (wr_resp_valid),
    .wres_ready (wr_resp_ready),
    .ram_r      (ram_r.master),
    .ram_w      (ram_w.master)
  );

  // memory answers both channels
  axi_sram #(
    .MEM_DEPTH (MEM_DEPTH)
  ) i_sram (
    .clk  (clk),
    .rstn (rstn),
    .s_r  (ram_r.slave),
    .s_w  (ram_w.slave)
  );

endmodule

`default_nettype wire

// File: sim/tb_lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top;
  import lsu_pkg::*;

  logic        clk;
  logic        rstn;
  logic        rd_req_valid;
  logic        rd_req_ready;
  logic [31:0] rd_addr;
  load_func_t  rd_func;
  logic        rd_resp_valid;
  logic        rd_resp_ready;
  logic [31:0] rd_data;
  logic        wr_req_valid;
  logic        wr_req_ready;
  logic [31:0] wr_addr;
  logic [31:0] wr_data;
  store_func_t wr_func;
  logic        wr_resp_valid;
  logic        wr_resp_ready;

  // one entry per data line
  string       names[$];
  string       ops[$];
  logic [2:0]  funcs[$];
  logic [31:0] addrs[$];
  logic [31:0] vals[$];

  logic [31:0] rng;
  int          cycles;
  int          limit;
  int          rd_reqs;
  int          rd_resps;
  int          wr_reqs;
  int          wr_resps;

  lsu_top #(
    .MEM_DEPTH (256)
  ) i_dut (
    .clk           (clk),
    .rstn          (rstn),
    .rd_req_valid  (rd_req_valid),
    .rd_req_ready  (rd_req_ready),
    .rd_addr       (rd_addr),
    .rd_func       (rd_func),
    .rd_resp_valid (rd_resp_valid),
    .rd_resp_ready (rd_resp_ready),
    .rd_data       (rd_data),
    .wr_req_valid  (wr_req_valid),
    .wr_req_ready  (wr_req_ready),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wr_func       (wr_func),
    .wr_resp_valid (wr_resp_valid),
    .wr_resp_ready (wr_resp_ready)
  );

  always #50 clk = ~clk;

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // handshake counts and the run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (rstn) begin
      if (rd_req_valid && rd_req_ready) begin
        rd_reqs <= rd_reqs + 1;
      end
      if (rd_resp_valid && rd_resp_ready) begin
        rd_resps <= rd_resps + 1;
      end
      if (wr_req_valid && wr_req_ready) begin
        wr_reqs <= wr_reqs + 1;
      end
      if (wr_resp_valid && wr_resp_ready) begin
        wr_resps <= wr_resps + 1;
      end
    end
    assert (cycles < limit)
      else stop_on_error($sformatf("timeout, the run did not finish in %0d cycles", limit));
  end

  task automatic run_load(input int idx, input int d);
    @(posedge clk);
    #1;
    rd_req_valid  = 1'b1;
    rd_addr       = addrs[idx];
    rd_func       = load_func_t'(funcs[idx]);
    rd_resp_ready = (d == 0);
    @(posedge clk);
    while (!rd_req_ready) begin
      @(posedge clk);
    end
    assert (!rd_resp_valid)
      else stop_on_error({names[idx], ": load response valid before the request was taken"});
    #1;
    rd_req_valid = 1'b0;
    // response due at the first edge after acceptance
    @(posedge clk);
    assert (rd_resp_valid)
      else stop_on_error({names[idx], ": load response missing one cycle after the request"});
    for (int k = 0; k < d; k++) begin
      assert (rd_resp_valid && !rd_req_ready)
        else stop_on_error({names[idx], ": load response or request ready wrong while held"});
      assert (rd_data == vals[idx])
        else stop_on_error($sformatf("ERR %s expected %h actual %h",
                                     names[idx], vals[idx], rd_data));
      if (k == d - 1) begin
        #1;
        rd_resp_ready = 1'b1;
      end
      @(posedge clk);
    end
    assert (rd_resp_valid)
      else stop_on_error({names[idx], ": load response lost before it was taken"});
    assert (rd_data == vals[idx])
      else stop_on_error($sformatf("ERR %s expected %h actual %h",
                                   names[idx], vals[idx], rd_data));
    @(posedge clk);
    assert (!rd_resp_valid)
      else stop_on_error({names[idx], ": load response still valid after it was taken"});
  endtask

  task automatic run_store(input int idx, input int d);
    @(posedge clk);
    #1;
    wr_req_valid  = 1'b1;
    wr_addr       = addrs[idx];
    wr_data       = vals[idx];
    wr_func       = store_func_t'(funcs[idx]);
    wr_resp_ready = (d == 0);
    @(posedge clk);
    while (!wr_req_ready) begin
      @(posedge clk);
    end
    assert (!wr_resp_valid)
      else stop_on_error({names[idx], ": store response valid before the request was taken"});
    #1;
    wr_req_valid = 1'b0;
    @(posedge clk);
    assert (wr_resp_valid)
      else stop_on_error({names[idx], ": store response missing one cycle after the request"});
    for (int k = 0; k < d; k++) begin
      assert (wr_resp_valid && !wr_req_ready)
        else stop_on_error({names[idx], ": store response or request ready wrong while held"});
      if (k == d - 1) begin
        #1;
        wr_resp_ready = 1'b1;
      end
      @(posedge clk);
    end
    assert (wr_resp_valid)
      else stop_on_error({names[idx], ": store response lost before it was taken"});
    @(posedge clk);
    assert (!wr_resp_valid)
      else stop_on_error({names[idx], ": store response still valid after it was taken"});
  endtask

  initial begin : main
    int          fd;
    int          rc;
    int          i;
    int          d_st;
    int          d_ld;
    int          n_loads;
    int          n_stores;
    string       line;
    string       t_name;
    string       t_op;
    logic [31:0] t_func;
    logic [31:0] t_addr;
    logic [31:0] t_val;

    clk           = 1'b0;
    rstn          = 1'b0;
    rd_req_valid  = 1'b0;
    rd_addr       = '0;
    rd_func       = LD_W;
    rd_resp_ready = 1'b1;
    wr_req_valid  = 1'b0;
    wr_addr       = '0;
    wr_data       = '0;
    wr_func       = ST_W;
    wr_resp_ready = 1'b1;
    rng           = 32'h23deac29;
    cycles        = 0;
    limit         = 100;
    rd_reqs       = 0;
    rd_resps      = 0;
    wr_reqs       = 0;
    wr_resps      = 0;
    n_loads       = 0;
    n_stores      = 0;

    fd = $fopen("sim/lsu_testdata.txt", "r");
    assert (fd != 0) else stop_on_error("could not open sim/lsu_testdata.txt");
    while (!$feof(fd)) begin
      line = "";
      rc = $fgets(line, fd);
      // blank lines and comments carry no vector
      if (line.len() > 1 && line[0] != "#") begin
        rc = $sscanf(line, "%s %s %h %h %h", t_name, t_op, t_func, t_addr, t_val);
        assert (rc == 5 && (t_op == "ld" || t_op == "st" || t_op == "st+"))
          else stop_on_error({"malformed test data line: ", line});
        names.push_back(t_name);
        ops.push_back(t_op);
        funcs.push_back(t_func[2:0]);
        addrs.push_back(t_addr);
        vals.push_back(t_val);
        if (t_op == "ld") begin
          n_loads++;
        end else begin
          n_stores++;
        end
      end
    end
    $fclose(fd);
    limit = 100 + 20 * names.size();

    repeat (10) @(posedge clk);
    #1;
    rstn = 1'b1;

    i = 0;
    while (i < names.size()) begin
      rng  = xorshift32(rng);
      d_st = rng[1:0];
      rng  = xorshift32(rng);
      d_ld = rng[1:0];
      if (ops[i] == "st+") begin
        assert (i + 1 < names.size() && ops[i + 1] == "ld")
          else stop_on_error({"paired store is not followed by a load: ", names[i]});
        // store and load offered in the same cycle
        fork
          run_store(i, d_st);
          run_load(i + 1, d_ld);
        join
        i += 2;
      end else if (ops[i] == "st") begin
        run_store(i, d_st);
        i++;
      end else begin
        run_load(i, d_ld);
        i++;
      end
    end

    repeat (2) @(posedge clk);
    assert (rd_reqs == n_loads)
      else stop_on_error($sformatf("ERR load_requests expected %0d actual %0d", n_loads, rd_reqs));
    assert (rd_resps == n_loads)
      else stop_on_error($sformatf("ERR load_responses expected %0d actual %0d", n_loads, rd_resps));
    assert (wr_reqs == n_stores)
      else stop_on_error($sformatf("ERR store_requests expected %0d actual %0d", n_stores, wr_reqs));
    assert (wr_resps == n_stores)
      else stop_on_error($sformatf("ERR store_responses expected %0d actual %0d", n_stores, wr_resps));
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/lsu_testdata.txt
# name op func addr data; op is ld, st, or st+ (store issued with the load on the next line)
# func is the funct3 code in hex, addr and data in hex, data is the expected value for ld
w_lo      st  2 00000100 11223344
w_hi      st  2 00000104 a5b6c7d8
w_lo_rd   ld  2 00000100 11223344
w_hi_rd   ld  2 00000104 a5b6c7d8
mrg_word  st  2 00000108 01020304
mrg_h2    st  1 0000010a 9999ccdd
mrg_b1    st  0 00000109 777777aa
mrg_b3    st  0 0000010b 000000bb
mrg_rd    ld  2 00000108 bbddaa04
ext_word  st  2 00000110 80417fc3
bs_off0   ld  0 00000110 ffffffc3
bs_off1   ld  0 00000111 0000007f
bs_off2   ld  0 00000112 00000041
bs_off3   ld  0 00000113 ffffff80
bu_off0   ld  4 00000110 000000c3
bu_off1   ld  4 00000111 0000007f
bu_off2   ld  4 00000112 00000041
bu_off3   ld  4 00000113 00000080
hs_set    ld  1 00000104 ffffc7d8
hs_clr    ld  1 00000102 00001122
hu_set    ld  5 00000106 0000a5b6
hu_clr    ld  5 00000100 00003344
cc_st1    st+ 2 00000200 cafef00d
cc_ld1    ld  2 00000104 a5b6c7d8
cc_chk1   ld  2 00000200 cafef00d
cc_st2    st+ 0 00000205 1234565a
cc_ld2    ld  0 00000111 0000007f
cc_chk2   ld  4 00000205 0000005a

// File: sim.f
source/lsu_pkg.sv
source/axi_pkg.sv
source/axi_lite_r_if.sv
source/axi_w_if.sv
source/lsu.sv
source/axi_sram.sv
source/lsu_top.sv
sim/tb_lsu_top.sv
